// File: Makefile
TOP := conv_engine_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f compile.f
	verilator --lint-only --top-module conv_engine_top rtl/conv_pkg.sv rtl/dual_port_ram.sv \
		rtl/mac_array.sv rtl/conv_controller.sv rtl/result_drain.sv rtl/conv_engine_top.sv

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f compile.f -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP) +verilator+error+limit+1000)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Simulation passed"

clean:
	rm -rf obj_dir

// File: compile.f
rtl/conv_pkg.sv
rtl/dual_port_ram.sv
rtl/mac_array.sv
rtl/conv_controller.sv
rtl/result_drain.sv
rtl/conv_engine_top.sv
verif/conv_engine_props.sv
verif/conv_engine_tb.sv

// File: rtl/conv_controller.sv
`default_nettype none

module conv_controller
    import conv_pkg::*;
(
    input  wire logic                       clk_i,
    input  wire logic                       rd_weight_rst,
    input  wire logic                       start_i,
    input  wire conv_cmd_t                  cmd_i,
    input  wire logic [SLOT_WIDTH-1:0]      free_slots_i,
    input  wire logic                       drain_empty_i,
    input  wire logic                       acc_valid_i,
    output logic                            wt_rd_en_o,
    output logic      [WT_ADDR_WIDTH-1:0]   wt_rd_addr_o,
    output logic                            wt_load_o,
    output logic      [WT_ADDR_WIDTH-1:0]   wt_sel_o,
    output logic                            feat_rd_en_o,
    output logic      [FEAT_ADDR_WIDTH-1:0] feat_rd_addr_o,
    output logic                            feat_valid_o,
    output logic      [FEAT_ADDR_WIDTH-1:0] feat_pos_o,
    output logic                            busy_o,
    output logic                            done_o
);

    ctrl_state_e state_q;
    ctrl_state_e state_d;
    logic [WT_ADDR_WIDTH-1:0] wt_cnt_q;
    logic [FEAT_ADDR_WIDTH-1:0] pos_cnt_q;
    logic [FEAT_ADDR_WIDTH:0] num_pos_q;
    // vectors between feature read and drain input
    logic [SLOT_WIDTH-1:0] inflight_q;
    logic start_ok;
    logic issue;
    logic last_wt;
    logic last_pos;
    logic drained;

    assign busy_o = (state_q == LOAD_W) || (state_q == STREAM) || (state_q == FLUSH);
    assign done_o = (state_q == DONE);
    assign start_ok = start_i && !busy_o;

    assign last_wt = (wt_cnt_q == WT_ADDR_WIDTH'(COLS - 1));
    assign last_pos = ({1'b0, pos_cnt_q} == num_pos_q - 1'b1);
    assign drained = (inflight_q == '0) && drain_empty_i;

    // only issue what the drain is sure to have room for
    assign issue = (state_q == STREAM) && (inflight_q < free_slots_i);

    assign wt_rd_en_o = (state_q == LOAD_W);
    assign wt_rd_addr_o = wt_cnt_q;
    assign feat_rd_en_o = issue;
    assign feat_rd_addr_o = pos_cnt_q;

    ////////////////////
    // next state
    ////////////////////
    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE, DONE: begin
                if (start_ok) begin
                    state_d = LOAD_W;
                end else begin
                    state_d = IDLE;
                end
            end
            LOAD_W: begin
                if (last_wt) begin
                    state_d = STREAM;
                end
            end
            STREAM: begin
                if (issue && last_pos) begin
                    state_d = FLUSH;
                end
            end
            FLUSH: begin
                if (drained) begin
                    state_d = DONE;
                end
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    ////////////////////
    // counters and strobes
    ////////////////////
    always_ff @(posedge clk_i or posedge rd_weight_rst) begin
        if (rd_weight_rst) begin
            state_q <= IDLE;
            wt_cnt_q <= '0;
            pos_cnt_q <= '0;
            num_pos_q <= '0;
            inflight_q <= '0;
            wt_load_o <= 1'b0;
            feat_valid_o <= 1'b0;
        end else begin
            state_q <= state_d;
            // read data arrives a cycle later
            wt_load_o <= wt_rd_en_o;
            feat_valid_o <= feat_rd_en_o;

            if (start_ok) begin
                num_pos_q <= cmd_i.num_pos;
                wt_cnt_q <= '0;
                pos_cnt_q <= '0;
            end else begin
                if (wt_rd_en_o) begin
                    wt_cnt_q <= wt_cnt_q + 1'b1;
                end
                if (issue) begin
                    pos_cnt_q <= pos_cnt_q + 1'b1;
                end
            end

            case ({issue, acc_valid_i})
                2'b10: inflight_q <= inflight_q + 1'b1;
                2'b01: inflight_q <= inflight_q - 1'b1;
                default: inflight_q <= inflight_q;
            endcase
        end
    end

    // select and position follow their strobes
    always_ff @(posedge clk_i) begin
        wt_sel_o <= wt_rd_addr_o;
        feat_pos_o <= feat_rd_addr_o;
    end

endmodule

`default_nettype wire

// File: rtl/conv_engine_top.sv
`default_nettype none

module conv_engine_top
    import conv_pkg::*;
(
    input  wire logic      clk_i,
    input  wire logic      rd_weight_rst,
    input  wire feat_wr_t  feat_wr_i,
    input  wire wt_wr_t    wt_wr_i,
    input  wire logic      start_i,
    input  wire conv_cmd_t cmd_i,
    input  wire logic      credit_i,
    output logic           valid_o,
    output result_t        result_o,
    output logic           busy_o,
    output logic           done_o
);

    // memory read side
    logic feat_rd_en;
    logic [FEAT_ADDR_WIDTH-1:0] feat_rd_addr;
    feat_vec_t feat_rd_data;
    logic wt_rd_en;
    logic [WT_ADDR_WIDTH-1:0] wt_rd_addr;
    wt_vec_t wt_rd_data;

    // array control
    logic wt_load;
    logic [WT_ADDR_WIDTH-1:0] wt_sel;
    logic vec_valid;
    logic [FEAT_ADDR_WIDTH-1:0] vec_pos;

    // array to drain
    logic acc_valid;
    logic [FEAT_ADDR_WIDTH-1:0] acc_pos;
    acc_vec_t acc_vec;
    logic [SLOT_WIDTH-1:0] free_slots;
    logic drain_empty;

    dual_port_ram #(
        .WIDTH      ($bits(feat_vec_t)),
        .ADDR_WIDTH (FEAT_ADDR_WIDTH)
    ) feature_mem (
        .clk_i     (clk_i),
        .wr_en_i   (feat_wr_i.en),
        .wr_addr_i (feat_wr_i.addr),
        .wr_data_i (feat_wr_i.data),
        .rd_en_i   (feat_rd_en),
        .rd_addr_i (feat_rd_addr),
        .rd_data_o (feat_rd_data)
    );

    dual_port_ram #(
        .WIDTH      ($bits(wt_vec_t)),
        .ADDR_WIDTH (WT_ADDR_WIDTH)
    ) weight_mem (
        .clk_i     (clk_i),
        .wr_en_i   (wt_wr_i.en),
        .wr_addr_i (wt_wr_i.addr),
        .wr_data_i (wt_wr_i.data),
        .rd_en_i   (wt_rd_en),
        .rd_addr_i (wt_rd_addr),
        .rd_data_o (wt_rd_data)
    );

    mac_array u_mac_array (
        .clk_i         (clk_i),
        .rd_weight_rst (rd_weight_rst),
        .wt_load_i     (wt_load),
        .wt_sel_i      (wt_sel),
        .wt_data_i     (wt_rd_data),
        .feat_valid_i  (vec_valid),
        .feat_pos_i    (vec_pos),
        .feat_i        (feat_rd_data),
        .acc_valid_o   (acc_valid),
        .acc_pos_o     (acc_pos),
        .acc_o         (acc_vec)
    );

    conv_controller u_conv_controller (
        .clk_i          (clk_i),
        .rd_weight_rst  (rd_weight_rst),
        .start_i        (start_i),
        .cmd_i          (cmd_i),
        .free_slots_i   (free_slots),
        .drain_empty_i  (drain_empty),
        .acc_valid_i    (acc_valid),
        .wt_rd_en_o     (wt_rd_en),
        .wt_rd_addr_o   (wt_rd_addr),
        .wt_load_o      (wt_load),
        .wt_sel_o       (wt_sel),
        .feat_rd_en_o   (feat_rd_en),
        .feat_rd_addr_o (feat_rd_addr),
        .feat_valid_o   (vec_valid),
        .feat_pos_o     (vec_pos),
        .busy_o         (busy_o),
        .done_o         (done_o)
    );

    result_drain u_result_drain (
        .clk_i         (clk_i),
        .rd_weight_rst (rd_weight_rst),
        .acc_valid_i   (acc_valid),
        .acc_pos_i     (acc_pos),
        .acc_i         (acc_vec),
        .credit_i      (credit_i),
        .free_slots_o  (free_slots),
        .empty_o       (drain_empty),
        .valid_o       (valid_o),
        .result_o      (result_o)
    );

endmodule

`default_nettype wire

// File: rtl/conv_pkg.sv
`default_nettype none

package conv_pkg;

    ////////////////////
    // array geometry
    ////////////////////
    localparam int ROWS = 4;
    localparam int COLS = 4;
    localparam int I_WIDTH = 8;
    localparam int F_WIDTH = 8;
    localparam int PROD_WIDTH = I_WIDTH + F_WIDTH;
    // headroom for summing ROWS products
    localparam int ACC_WIDTH = PROD_WIDTH + $clog2(ROWS);

    ////////////////////
    // memories and result buffering
    ////////////////////
    localparam int FEAT_ADDR_WIDTH = 6;
    localparam int WT_ADDR_WIDTH = $clog2(COLS);
    localparam int FIFO_DEPTH = 4;
    localparam int FIFO_PTR_WIDTH = $clog2(FIFO_DEPTH);
    localparam int SLOT_WIDTH = $clog2(FIFO_DEPTH + 1);
    localparam int CREDIT_MAX = 4;
    localparam int CREDIT_WIDTH = $clog2(CREDIT_MAX + 1);

    // named signed element types keep vector elements signed
    typedef logic signed [I_WIDTH-1:0] feat_t;
    typedef logic signed [F_WIDTH-1:0] wt_t;
    typedef logic signed [ACC_WIDTH-1:0] acc_t;

    typedef feat_t [ROWS-1:0] feat_vec_t;
    typedef wt_t [ROWS-1:0] wt_vec_t;
    typedef acc_t [COLS-1:0] acc_vec_t;

    typedef struct packed {
        logic en;
        logic [FEAT_ADDR_WIDTH-1:0] addr;
        feat_vec_t data;
    } feat_wr_t;

    typedef struct packed {
        logic en;
        logic [WT_ADDR_WIDTH-1:0] addr;
        wt_vec_t data;
    } wt_wr_t;

    // num_pos runs 1..64
    typedef struct packed {
        logic [FEAT_ADDR_WIDTH:0] num_pos;
    } conv_cmd_t;

    typedef struct packed {
        logic [FEAT_ADDR_WIDTH-1:0] pos;
        logic [WT_ADDR_WIDTH-1:0] filt;
        logic [ACC_WIDTH-1:0] value;
    } result_t;

    typedef enum logic [2:0] {
        IDLE,
        LOAD_W,
        STREAM,
        FLUSH,
        DONE
    } ctrl_state_e;

endpackage

`default_nettype wire

// File: rtl/dual_port_ram.sv
`default_nettype none

module dual_port_ram #(
    parameter int WIDTH = 32,
    parameter int ADDR_WIDTH = 6
) (
    input  wire logic                  clk_i,
    input  wire logic                  wr_en_i,
    input  wire logic [ADDR_WIDTH-1:0] wr_addr_i,
    input  wire logic [WIDTH-1:0]      wr_data_i,
    input  wire logic                  rd_en_i,
    input  wire logic [ADDR_WIDTH-1:0] rd_addr_i,
    output logic      [WIDTH-1:0]      rd_data_o
);

    logic [WIDTH-1:0] mem [2**ADDR_WIDTH];

    always_ff @(posedge clk_i) begin
        if (wr_en_i) begin
            mem[wr_addr_i] <= wr_data_i;
        end
    end

    // read data holds between reads
    always_ff @(posedge clk_i) begin
        if (rd_en_i) begin
            rd_data_o <= mem[rd_addr_i];
        end
    end

endmodule

`default_nettype wire

// File: rtl/mac_array.sv
`default_nettype none

module mac_array
    import conv_pkg::*;
(
    input  wire logic                       clk_i,
    input  wire logic                       rd_weight_rst,
    input  wire logic                       wt_load_i,
    input  wire logic [WT_ADDR_WIDTH-1:0]   wt_sel_i,
    input  wire wt_vec_t                    wt_data_i,
    input  wire logic                       feat_valid_i,
    input  wire logic [FEAT_ADDR_WIDTH-1:0] feat_pos_i,
    input  wire feat_vec_t                  feat_i,
    output logic                            acc_valid_o,
    output logic      [FEAT_ADDR_WIDTH-1:0] acc_pos_o,
    output acc_vec_t                        acc_o
);

    wt_vec_t wt_q [COLS];
    logic signed [PROD_WIDTH-1:0] prod_q [COLS][ROWS];
    acc_t sum_d [COLS];
    logic v1_q;
    logic v2_q;
    logic [FEAT_ADDR_WIDTH-1:0] pos1_q;
    logic [FEAT_ADDR_WIDTH-1:0] pos2_q;
    acc_vec_t acc_q;

    // stationary weights, one filter per column
    always_ff @(posedge clk_i or posedge rd_weight_rst) begin
        if (rd_weight_rst) begin
            for (int c = 0; c < COLS; c++) begin
                wt_q[c] <= '0;
            end
        end else if (wt_load_i) begin
            wt_q[wt_sel_i] <= wt_data_i;
        end
    end

    always_ff @(posedge clk_i or posedge rd_weight_rst) begin
        if (rd_weight_rst) begin
            v1_q <= 1'b0;
            v2_q <= 1'b0;
        end else begin
            v1_q <= feat_valid_i;
            v2_q <= v1_q;
        end
    end

    ////////////////////
    // stage 1 products
    ////////////////////
    always_ff @(posedge clk_i) begin
        if (feat_valid_i) begin
            pos1_q <= feat_pos_i;
            for (int c = 0; c < COLS; c++) begin
                for (int r = 0; r < ROWS; r++) begin
                    prod_q[c][r] <= $signed(feat_i[r]) * $signed(wt_q[c][r]);
                end
            end
        end
    end

    ////////////////////
    // stage 2 column sums
    ////////////////////
    always_comb begin
        for (int c = 0; c < COLS; c++) begin
            sum_d[c] = '0;
            for (int r = 0; r < ROWS; r++) begin
                sum_d[c] = sum_d[c] + ACC_WIDTH'(prod_q[c][r]);
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (v1_q) begin
            pos2_q <= pos1_q;
            for (int c = 0; c < COLS; c++) begin
                acc_q[c] <= sum_d[c];
            end
        end
    end

    assign acc_valid_o = v2_q;
    assign acc_pos_o = pos2_q;
    assign acc_o = acc_q;

endmodule

`default_nettype wire

// File: rtl/result_drain.sv
`default_nettype none

module result_drain
    import conv_pkg::*;
(
    input  wire logic                       clk_i,
    input  wire logic                       rd_weight_rst,
    input  wire logic                       acc_valid_i,
    input  wire logic [FEAT_ADDR_WIDTH-1:0] acc_pos_i,
    input  wire acc_vec_t                   acc_i,
    input  wire logic                       credit_i,
    output logic      [SLOT_WIDTH-1:0]      free_slots_o,
    output logic                            empty_o,
    output logic                            valid_o,
    output result_t                         result_o
);

    acc_vec_t vec_mem [FIFO_DEPTH];
    logic [FEAT_ADDR_WIDTH-1:0] pos_mem [FIFO_DEPTH];
    logic [FIFO_PTR_WIDTH-1:0] wr_ptr;
    logic [FIFO_PTR_WIDTH-1:0] rd_ptr;
    logic [SLOT_WIDTH-1:0] fifo_cnt;
    // filter index within the head vector
    logic [WT_ADDR_WIDTH-1:0] col_idx;
    logic [CREDIT_WIDTH-1:0] credit_cnt;
    logic push;
    logic fire;
    logic pop;
    acc_vec_t head_vec;

    assign push = acc_valid_i;
    assign fire = (fifo_cnt != '0) && (credit_cnt != '0);
    assign pop = fire && (col_idx == WT_ADDR_WIDTH'(COLS - 1));
    assign head_vec = vec_mem[rd_ptr];

    assign valid_o = fire;
    assign empty_o = (fifo_cnt == '0);
    assign free_slots_o = SLOT_WIDTH'(FIFO_DEPTH) - fifo_cnt;

    always_comb begin
        result_o.pos = pos_mem[rd_ptr];
        result_o.filt = col_idx;
        result_o.value = head_vec[col_idx];
    end

    ////////////////////
    // vector storage
    ////////////////////
    always_ff @(posedge clk_i) begin
        if (push) begin
            vec_mem[wr_ptr] <= acc_i;
            pos_mem[wr_ptr] <= acc_pos_i;
        end
    end

    always_ff @(posedge clk_i or posedge rd_weight_rst) begin
        if (rd_weight_rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            fifo_cnt <= '0;
            col_idx <= '0;
            credit_cnt <= CREDIT_WIDTH'(CREDIT_MAX);
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (fire) begin
                col_idx <= col_idx + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end

            case ({push, pop})
                2'b10: fifo_cnt <= fifo_cnt + 1'b1;
                2'b01: fifo_cnt <= fifo_cnt - 1'b1;
                default: fifo_cnt <= fifo_cnt;
            endcase

            // one credit spent per result, one back per credit pulse
            case ({credit_i, fire})
                2'b10: credit_cnt <= credit_cnt + 1'b1;
                2'b01: credit_cnt <= credit_cnt - 1'b1;
                default: credit_cnt <= credit_cnt;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: verif/conv_engine_props.sv
`default_nettype none

module conv_engine_props
    import conv_pkg::*;
(
    input wire logic                    clk_i,
    input wire logic                    rd_weight_rst,
    input wire logic                    valid_i,
    input wire logic                    credit_i,
    input wire logic                    push_i,
    input wire logic [SLOT_WIDTH-1:0]   free_slots_i,
    input wire logic [CREDIT_WIDTH-1:0] credit_cnt_i
);

    // number of failed properties so far
    int fail_cnt = 0;

    // credits as the consumer sees them on the interface
    logic [CREDIT_WIDTH-1:0] credits_q;

    always_ff @(posedge clk_i or posedge rd_weight_rst) begin
        if (rd_weight_rst) begin
            credits_q <= CREDIT_WIDTH'(CREDIT_MAX);
        end else if (credit_i && !valid_i) begin
            credits_q <= credits_q + 1'b1;
        end else if (valid_i && !credit_i) begin
            credits_q <= credits_q - 1'b1;
        end
    end

    ////////////////////
    // credit protocol
    ////////////////////
    valid_needs_credit: assert property (
        @(posedge clk_i) disable iff (rd_weight_rst)
        valid_i |-> credits_q != '0
    ) else begin
        $error("valid_o asserted with no credit left");
        fail_cnt++;
    end

    credit_bounded: assert property (
        @(posedge clk_i) disable iff (rd_weight_rst)
        credit_cnt_i <= CREDIT_WIDTH'(CREDIT_MAX)
    ) else begin
        $error("credit count above its maximum");
        fail_cnt++;
    end

    ////////////////////
    // FIFO
    ////////////////////
    no_push_when_full: assert property (
        @(posedge clk_i) disable iff (rd_weight_rst)
        push_i |-> free_slots_i != '0
    ) else begin
        $error("result FIFO written with no free slot");
        fail_cnt++;
    end

endmodule

bind result_drain conv_engine_props u_props (
    .clk_i         (clk_i),
    .rd_weight_rst (rd_weight_rst),
    .valid_i       (valid_o),
    .credit_i      (credit_i),
    .push_i        (push),
    .free_slots_i  (free_slots_o),
    .credit_cnt_i  (credit_cnt)
);

`default_nettype wire

// File: verif/conv_engine_tb.sv
`default_nettype none

module conv_engine_tb
    import conv_pkg::*;
();

    logic clk_i = 1'b0;
    logic rd_weight_rst;
    feat_wr_t feat_wr;
    wt_wr_t wt_wr;
    logic start;
    conv_cmd_t cmd;
    logic credit = 1'b0;
    logic valid;
    result_t result;
    logic busy;
    logic done;

    // reference copies of both memories
    feat_vec_t feat_ref [2**FEAT_ADDR_WIDTH];
    wt_vec_t wt_ref [COLS];

    logic [15:0] data_lfsr = 16'd17;
    logic [15:0] gap_lfsr = 16'd17;
    logic withhold = 1'b0;
    logic hung = 1'b0;
    int err_cnt = 0;
    int test_cnt = 0;
    int failed_cnt = 0;
    int got_cnt = 0;
    int exp_total = 0;
    int exp_pos = 0;
    int exp_filt = 0;
    int held_cnt = 0;
    int done_cnt = 0;
    int owed = 0;
    int gap = 0;

    always #10 clk_i = ~clk_i;

    conv_engine_top uut (
        .clk_i         (clk_i),
        .rd_weight_rst (rd_weight_rst),
        .feat_wr_i     (feat_wr),
        .wt_wr_i       (wt_wr),
        .start_i       (start),
        .cmd_i         (cmd),
        .credit_i      (credit),
        .valid_o       (valid),
        .result_o      (result),
        .busy_o        (busy),
        .done_o        (done)
    );

    ////////////////////
    // random numbers
    ////////////////////
    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        logic fb;
        fb = s[15] ^ s[13] ^ s[12] ^ s[10];
        return {s[14:0], fb};
    endfunction

    task automatic draw_bits(inout logic [15:0] st, input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            st = lfsr_next(st);
            v = {v[30:0], st[0]};
        end
    endtask

    // signed dot product of one position with one filter
    function automatic logic [ACC_WIDTH-1:0] expect_value(input int pos, input int filt);
        int sum;
        sum = 0;
        for (int r = 0; r < ROWS; r++) begin
            sum += int'(feat_ref[pos][r]) * int'(wt_ref[filt][r]);
        end
        return ACC_WIDTH'(sum);
    endfunction

    function automatic int error_total();
        return err_cnt + uut.u_result_drain.u_props.fail_cnt;
    endfunction

    ////////////////////
    // checks
    ////////////////////
    task automatic expect_bit(input string name, input logic got, input logic want);
        assert (got === want) else begin
            $display("[ERROR] %s got %h expected %h", name, got, want);
            err_cnt++;
        end
    endtask

    task automatic expect_count(input string name, input int got, input int want);
        assert (got == want) else begin
            $display("[ERROR] %s got %h expected %h", name, got, want);
            err_cnt++;
        end
    endtask

    task automatic check_idle();
        expect_bit("valid_o", valid, 1'b0);
        expect_bit("busy_o", busy, 1'b0);
        expect_bit("done_o", done, 1'b0);
    endtask

    // results must come in position order, filters 0 to COLS-1 within each
    task automatic check_output();
        logic [ACC_WIDTH-1:0] exp_val;
        if (!rd_weight_rst && valid) begin
            assert (got_cnt < exp_total) else begin
                $display("result arrived after all %0d expected results", exp_total);
                err_cnt++;
            end
            if (got_cnt < exp_total) begin
                exp_val = expect_value(exp_pos, exp_filt);
                assert (int'(result.pos) == exp_pos) else begin
                    $display("[ERROR] result_o.pos got %h expected %h",
                             result.pos, FEAT_ADDR_WIDTH'(exp_pos));
                    err_cnt++;
                end
                assert (int'(result.filt) == exp_filt) else begin
                    $display("[ERROR] result_o.filt got %h expected %h",
                             result.filt, WT_ADDR_WIDTH'(exp_filt));
                    err_cnt++;
                end
                assert (result.value === exp_val) else begin
                    $display("[ERROR] result_o.value got %h expected %h", result.value, exp_val);
                    err_cnt++;
                end
            end
            exp_filt++;
            if (exp_filt == COLS) begin
                exp_filt = 0;
                exp_pos++;
            end
            got_cnt++;
            if (withhold) begin
                held_cnt++;
            end
        end
    endtask

    // hand back one credit per consumed result, after a random gap
    task automatic drive_credit();
        logic [31:0] bits;
        credit = 1'b0;
        if (rd_weight_rst) begin
            owed = 0;
        end else begin
            if (valid) begin
                owed++;
            end
            if (!withhold && owed > 0) begin
                if (gap == 0) begin
                    credit = 1'b1;
                    owed--;
                    draw_bits(gap_lfsr, 2, bits);
                    gap = int'(bits);
                end else begin
                    gap--;
                end
            end
        end
    endtask

    task automatic tick();
        @(negedge clk_i);
        check_output();
        drive_credit();
        if (done) begin
            done_cnt++;
        end
    endtask

    ////////////////////
    // waits
    ////////////////////
    task automatic wait_results(input int count, input int limit);
        int n;
        n = 0;
        while (got_cnt < count && !hung) begin
            tick();
            n++;
            if (n >= limit && got_cnt < count) begin
                $display("timeout: only %0d of %0d results within %0d cycles", got_cnt, count, limit);
                hung = 1'b1;
                err_cnt++;
            end
        end
    endtask

    task automatic wait_done(input int limit);
        int n;
        n = 0;
        while (done_cnt == 0 && !hung) begin
            tick();
            n++;
            if (n >= limit && done_cnt == 0) begin
                $display("timeout: done_o did not pulse within %0d cycles", limit);
                hung = 1'b1;
                err_cnt++;
            end
        end
    endtask

    ////////////////////
    // stimulus
    ////////////////////
    task automatic load_memories(input int n);
        logic [31:0] bits;
        for (int c = 0; c < COLS; c++) begin
            draw_bits(data_lfsr, ROWS * F_WIDTH, bits);
            wt_ref[c] = wt_vec_t'(bits);
            tick();
            wt_wr.en = 1'b1;
            wt_wr.addr = WT_ADDR_WIDTH'(c);
            wt_wr.data = wt_ref[c];
        end
        for (int p = 0; p < n; p++) begin
            draw_bits(data_lfsr, ROWS * I_WIDTH, bits);
            feat_ref[p] = feat_vec_t'(bits);
            tick();
            wt_wr.en = 1'b0;
            feat_wr.en = 1'b1;
            feat_wr.addr = FEAT_ADDR_WIDTH'(p);
            feat_wr.data = feat_ref[p];
        end
        tick();
        wt_wr.en = 1'b0;
        feat_wr.en = 1'b0;
    endtask

    task automatic run_conv(input int n, input logic hold);
        load_memories(n);
        exp_total = n * COLS;
        got_cnt = 0;
        exp_pos = 0;
        exp_filt = 0;
        done_cnt = 0;
        tick();
        start = 1'b1;
        cmd.num_pos = (FEAT_ADDR_WIDTH + 1)'(n);
        tick();
        start = 1'b0;
        expect_bit("busy_o", busy, 1'b1);
        if (hold) begin
            wait_results(2, 400);
            held_cnt = 0;
            withhold = 1'b1;
            repeat (40) tick();
            withhold = 1'b0;
            assert (held_cnt <= CREDIT_MAX) else begin
                $display("[ERROR] results without credit got %h expected at most %h",
                         held_cnt, CREDIT_MAX);
                err_cnt++;
            end
        end
        wait_done(4000);
        expect_bit("busy_o", busy, 1'b0);
        expect_count("result count", got_cnt, exp_total);
        repeat (3) tick();
        expect_count("done_o pulses", done_cnt, 1);
        expect_count("result count", got_cnt, exp_total);
        expect_bit("busy_o", busy, 1'b0);
    endtask

    task automatic report_test(input string name, input int errs_before);
        int errs;
        errs = error_total() - errs_before;
        test_cnt++;
        if (errs == 0) begin
            $display("test %-16s ok", name);
        end else begin
            $display("test %-16s FAILED with %0d errors", name, errs);
            failed_cnt++;
        end
    endtask

    initial begin
        int errs_before;
        rd_weight_rst = 1'b1;
        feat_wr = '0;
        wt_wr = '0;
        start = 1'b0;
        cmd = '0;

        errs_before = error_total();
        repeat (8) begin
            tick();
            check_idle();
        end
        rd_weight_rst = 1'b0;
        repeat (5) begin
            tick();
            check_idle();
        end
        report_test("reset_idle", errs_before);

        errs_before = error_total();
        run_conv(8, 1'b0);
        report_test("basic_8", errs_before);

        errs_before = error_total();
        run_conv(20, 1'b1);
        report_test("credit_hold_20", errs_before);

        // new data and a longer command
        errs_before = error_total();
        run_conv(64, 1'b0);
        report_test("rerun_64", errs_before);

        $display("tests run %0d, tests failed %0d, errors %0d",
                 test_cnt, failed_cnt, error_total());
        if (error_total() == 0 && failed_cnt == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
